// ==== build.f ====
src/x25519_pkg.sv
src/wb_if.sv
src/limb_ram.sv
src/wb_arbiter.sv
src/mult_pass.sv
src/mult_sequencer.sv
src/x25519_mul_top.sv
dv/x25519_mul_checker.sv
dv/x25519_mul_tb.sv

// ==== dv/x25519_mul_checker.sv ====
module x25519_mul_checker (
	input logic clk,
	input logic arst_n,
	input logic host_cyc,
	input logic host_stb,
	input logic host_ack,
	input logic busy,
	input logic done,
	input logic pass_en,
	input logic limb_valid
);
	timeunit 1ns;
	timeprecision 100ps;
	import x25519_pkg::*;

	// Failed assertions so far, the testbench polls this
	int unsigned fail_cnt = 0;

	//////////////////////////////////////////////////
	// Host handshake

	// Ack only answers a live host request
	host_ack_qualified: assert property (@(posedge clk) disable iff (!arst_n)
		host_ack |-> host_cyc && host_stb)
		else begin
			$error("host_ack high without host_cyc and host_stb");
			fail_cnt++;
		end

	//////////////////////////////////////////////////
	// Status

	// Single-cycle done pulse
	done_one_cycle: assert property (@(posedge clk) disable iff (!arst_n)
		done |=> !done)
		else begin
			$error("done high for two cycles in a row");
			fail_cnt++;
		end

	// Back to idle right after done
	busy_drops_after_done: assert property (@(posedge clk) disable iff (!arst_n)
		done |=> !busy)
		else begin
			$error("busy still high the cycle after done");
			fail_cnt++;
		end

	//////////////////////////////////////////////////
	// Pass stream

	// Fixed pipeline depth, no stall
	pass_latency_fixed: assert property (@(posedge clk) disable iff (!arst_n)
		pass_en |-> ##PASS_LATENCY limb_valid)
		else begin
			$error("limb_valid missing PASS_LATENCY cycles after pass_en");
			fail_cnt++;
		end

endmodule

bind x25519_mul_top x25519_mul_checker u_checker (
	.clk        (clk),
	.arst_n     (arst_n),
	.host_cyc   (host_cyc),
	.host_stb   (host_stb),
	.host_ack   (host_ack),
	.busy       (busy),
	.done       (done),
	.pass_en    (pass_en),
	.limb_valid (limb_valid)
);

// ==== dv/x25519_mul_tb.sv ====
module x25519_mul_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import x25519_pkg::*;

	// Budget per multiplication plus margin for the memory test and reset
	localparam int RUNS = 8;
	localparam int CYCLE_LIMIT = RUNS * 400 + 2000;
	localparam wb_adr_t SCRATCH_BASE = 7'd96;

	logic clk;
	logic arst_n;
	logic start;
	logic host_cyc;
	logic host_stb;
	logic host_we;
	wb_adr_t host_adr;
	limb_t host_dat_w;
	limb_t host_dat_r;
	logic host_ack;
	logic busy;
	logic done;

	// Accepted starts, observed dones, elapsed clocks
	int starts;
	int dones;
	int cycles;

	x25519_mul_top u_dut (
		.clk        (clk),
		.arst_n     (arst_n),
		.start      (start),
		.host_cyc   (host_cyc),
		.host_stb   (host_stb),
		.host_we    (host_we),
		.host_adr   (host_adr),
		.host_dat_w (host_dat_w),
		.host_dat_r (host_dat_r),
		.host_ack   (host_ack),
		.busy       (busy),
		.done       (done)
	);

	always #2 clk = ~clk;

	//////////////////////////////////////////////////
	// Failure reporting

	task automatic abort_run(string why);
		$display("%s", why);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(string name, logic [31:0] expected, logic [31:0] actual);
		if (actual !== expected) begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
			abort_run("Value mismatch, see line above");
		end
	endtask

	// Hang guard
	always @(posedge clk) begin
		cycles++;
		if (cycles > CYCLE_LIMIT) begin
			abort_run($sformatf("Timeout after %0d cycles, DUT never finished", cycles));
		end
	end

	// Done counter and bound assertion watch
	always @(negedge clk) begin
		if (arst_n && done) begin
			dones++;
		end
		if (u_dut.u_checker.fail_cnt != 0) begin
			abort_run("An assertion in the bound checker failed");
		end
	end

	//////////////////////////////////////////////////
	// Host bus

	// Request stays up one negedge past ack and cyc then drops for a clock
	task automatic wb_write(wb_adr_t adr, limb_t data);
		@(negedge clk);
		host_cyc = 1'b1;
		host_stb = 1'b1;
		host_we = 1'b1;
		host_adr = adr;
		host_dat_w = data;
		do @(negedge clk); while (!host_ack);
		@(negedge clk);
		host_cyc = 1'b0;
		host_stb = 1'b0;
		host_we = 1'b0;
	endtask

	task automatic wb_read(wb_adr_t adr, output limb_t data);
		@(negedge clk);
		host_cyc = 1'b1;
		host_stb = 1'b1;
		host_we = 1'b0;
		host_adr = adr;
		do @(negedge clk); while (!host_ack);
		data = host_dat_r;
		@(negedge clk);
		host_cyc = 1'b0;
		host_stb = 1'b0;
	endtask

	//////////////////////////////////////////////////
	// Reference model

	// out[i] is the sum of a[j]*b[(i-j) mod 32] with terms j > i times 38 and all mod 2^32
	function automatic bignum_t ref_mul(bignum_t a, bignum_t b);
		bignum_t r;
		limb_t acc;
		limb_t t;
		for (int i = 0; i < NUM_LIMBS; i++) begin
			acc = '0;
			for (int j = 0; j < NUM_LIMBS; j++) begin
				t = a[j*32 +: 32] * b[((i - j + NUM_LIMBS) % NUM_LIMBS)*32 +: 32];
				if (j > i) begin
					t = t * 32'd38;
				end
				acc = acc + t;
			end
			r[i*32 +: 32] = acc;
		end
		return r;
	endfunction

	function automatic bignum_t rand_bignum();
		bignum_t r;
		for (int k = 0; k < NUM_LIMBS; k++) begin
			r[k*32 +: 32] = $urandom();
		end
		return r;
	endfunction

	//////////////////////////////////////////////////
	// Run control

	// Caller says whether the DUT should take this start
	task automatic pulse_start(bit accept);
		@(negedge clk);
		check_value("busy", accept ? 32'd0 : 32'd1, busy);
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		if (accept) begin
			starts++;
		end
		check_value("busy", 32'd1, busy);
	endtask

	// Scratch words 96 and up while the sequencer owns the bus now and then
	task automatic scratch_traffic();
		limb_t w;
		limb_t got;
		check_value("busy", 32'd1, busy);
		for (int k = 0; k < 4; k++) begin
			w = $urandom();
			wb_write(SCRATCH_BASE + wb_adr_t'(k), w);
			wb_read(SCRATCH_BASE + wb_adr_t'(k), got);
			check_value($sformatf("scratch[%0d]", k), w, got);
		end
	endtask

	// Reads the result area back and compares each limb
	task automatic compare_result(bignum_t expected);
		limb_t got;
		for (int k = 0; k < NUM_LIMBS; k++) begin
			wb_read(RES_BASE + wb_adr_t'(k), got);
			check_value($sformatf("res[%0d]", k), expected[k*32 +: 32], got);
		end
	endtask

	task automatic run_mul(bignum_t a, bignum_t b, bit with_traffic);
		bignum_t expected;
		for (int k = 0; k < NUM_LIMBS; k++) begin
			wb_write(OPA_BASE + wb_adr_t'(k), a[k*32 +: 32]);
			wb_write(OPB_BASE + wb_adr_t'(k), b[k*32 +: 32]);
		end
		expected = ref_mul(a, b);
		pulse_start(1'b1);
		if (with_traffic) begin
			// Second start lands mid-run
			pulse_start(1'b0);
			scratch_traffic();
		end
		wait (dones == starts);
		@(negedge clk);
		check_value("busy", 32'd0, busy);
		compare_result(expected);
	endtask

	//////////////////////////////////////////////////
	// Main sequence

	initial begin
		limb_t pattern [32];
		limb_t got;
		bignum_t a;
		bignum_t b;
		void'($urandom(32'he6bf85e9));
		clk = 1'b0;
		arst_n = 1'b0;
		start = 1'b0;
		host_cyc = 1'b0;
		host_stb = 1'b0;
		host_we = 1'b0;
		host_adr = '0;
		host_dat_w = '0;
		starts = 0;
		dones = 0;
		cycles = 0;
		repeat (10) @(posedge clk);
		@(negedge clk);
		arst_n = 1'b1;

		// Quiet after reset
		@(negedge clk);
		check_value("busy", 32'd0, busy);
		check_value("done", 32'd0, done);
		check_value("host_ack", 32'd0, host_ack);

		// Scratch memory write then read back
		for (int k = 0; k < 32; k++) begin
			pattern[k] = $urandom();
			wb_write(SCRATCH_BASE + wb_adr_t'(k), pattern[k]);
		end
		for (int k = 0; k < 32; k++) begin
			wb_read(SCRATCH_BASE + wb_adr_t'(k), got);
			check_value($sformatf("mem[%0d]", 96 + k), pattern[k], got);
		end

		// Five random runs and the fourth has host traffic and a stray start
		for (int r = 0; r < 5; r++) begin
			run_mul(rand_bignum(), rand_bignum(), r == 3);
		end

		// Edge operands
		run_mul('0, '0, 1'b0);
		run_mul({NUM_LIMBS{32'h0000_00ff}}, {NUM_LIMBS{32'h0000_00ff}}, 1'b0);
		a = '0;
		b = '0;
		// a[31]*b[5] lands on limb 4 with the x38 fold
		a[31*32 +: 32] = 32'd3;
		b[5*32 +: 32] = 32'd7;
		run_mul(a, b, 1'b0);

		repeat (4) @(negedge clk);
		check_value("done count", starts, dones);
		if (u_dut.u_checker.fail_cnt != 0) begin
			abort_run("An assertion in the bound checker failed");
		end else begin
			$display("*** PASSED ***");
			$finish;
		end
	end

endmodule

// ==== src/limb_ram.sv ====
module limb_ram (
	input logic clk,
	input logic arst_n,
	wb_if.slave bus
);
	import x25519_pkg::*;

	// Limb storage
	limb_t mem [MEM_WORDS];

	// Read word, valid while ack is high
	limb_t rd_data;

	logic ack_q;

	// Fresh request, ack is low so this is a new transfer
	logic req;

	assign req = bus.cyc && bus.stb && !ack_q;

	//////////////////////////////////////////////////
	// Handshake

	// Ack drops for a cycle after each transfer, two clocks per access
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			ack_q <= 1'b0;
		end else begin
			ack_q <= req;
		end
	end

	//////////////////////////////////////////////////
	// Array access

	always_ff @(posedge clk) begin
		if (req) begin
			if (bus.we) begin
				mem[bus.adr] <= bus.dat_w;
			end
			// old contents on a write
			rd_data <= mem[bus.adr];
		end
	end

	assign bus.ack = ack_q;
	assign bus.dat_r = rd_data;

endmodule

// ==== src/mult_pass.sv ====
module mult_pass (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  pass_en,
	input  x25519_pkg::pass_idx_t pass_idx,
	input  x25519_pkg::bignum_t   pass_a,
	input  x25519_pkg::bignum_t   pass_b,
	output logic                  limb_valid,
	output x25519_pkg::pass_idx_t limb_idx,
	output x25519_pkg::limb_t     limb
);
	import x25519_pkg::*;

	// Valid bit per stage, bit 0 is stage 1
	logic [PASS_LATENCY-1:0] vld_sr;
	// Pass index riding along
	pass_idx_t idx_sr [PASS_LATENCY];

	// Stage 1, raw products and fold mask
	limb_t prod [NUM_LIMBS];
	logic [NUM_LIMBS-1:0] fold;
	// Stage 2, terms after the x38 fold
	limb_t term [NUM_LIMBS];
	// Adder tree, 32 to 8 to 2 to 1
	limb_t sum8 [8];
	limb_t sum2 [2];

	// Four-input add, carries above bit 31 dropped
	function automatic limb_t sum4(limb_t w, limb_t x, limb_t y, limb_t z);
		return w + x + y + z;
	endfunction

	//////////////////////////////////////////////////
	// Control shift

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			vld_sr <= '0;
		end else begin
			vld_sr <= {vld_sr[PASS_LATENCY-2:0], pass_en};
		end
	end

	always_ff @(posedge clk) begin
		idx_sr[0] <= pass_idx;
		for (int s = 1; s < PASS_LATENCY; s++) begin
			idx_sr[s] <= idx_sr[s-1];
		end
	end

	//////////////////////////////////////////////////
	// Datapath

	always_ff @(posedge clk) begin
		// Lane j gets a[j] * b[(i-j) mod 32], rotation done by the sequencer
		if (pass_en) begin
			for (int j = 0; j < NUM_LIMBS; j++) begin
				prod[j] <= pass_a[j*32 +: 32] * pass_b[j*32 +: 32];
				fold[j] <= j > int'(pass_idx);
			end
		end
		// Lanes past the diagonal wrapped around the top
		if (vld_sr[0]) begin
			for (int j = 0; j < NUM_LIMBS; j++) begin
				term[j] <= fold[j] ? prod[j] * MUL38 : prod[j];
			end
		end
		if (vld_sr[1]) begin
			for (int k = 0; k < 8; k++) begin
				sum8[k] <= sum4(term[4*k], term[4*k+1], term[4*k+2], term[4*k+3]);
			end
		end
		if (vld_sr[2]) begin
			for (int k = 0; k < 2; k++) begin
				sum2[k] <= sum4(sum8[4*k], sum8[4*k+1], sum8[4*k+2], sum8[4*k+3]);
			end
		end
		// Final pair
		if (vld_sr[3]) begin
			limb <= sum2[0] + sum2[1];
		end
	end

	assign limb_valid = vld_sr[PASS_LATENCY-1];
	assign limb_idx = idx_sr[PASS_LATENCY-1];

endmodule

// ==== src/mult_sequencer.sv ====
module mult_sequencer (
	input  logic                  clk,
	input  logic                  arst_n,
	input  logic                  start,
	input  logic                  limb_valid,
	input  x25519_pkg::pass_idx_t limb_idx,
	input  x25519_pkg::limb_t     limb,
	output logic                  busy,
	output logic                  done,
	output logic                  pass_en,
	output x25519_pkg::pass_idx_t pass_idx,
	output x25519_pkg::bignum_t   pass_a,
	output x25519_pkg::bignum_t   pass_b,
	wb_if.master                  bus
);
	import x25519_pkg::*;

	seq_state_t state;

	// Bus transfers, 64 reads in LOAD then 32 writes in STORE
	logic [5:0] xfer_cnt;
	// Next pass to issue; bit 5 set once all 32 are out
	logic [5:0] issue_cnt;
	// Limbs back from the pass
	pass_idx_t arrive_cnt;

	// Operands and collected result
	bignum_t opa;
	bignum_t opb;
	bignum_t res;

	// B word k lands in lane -k mod 32, the layout for pass 0
	pass_idx_t load_lane;

	assign load_lane = '0 - xfer_cnt[4:0];

	//////////////////////////////////////////////////
	// FSM

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= IDLE;
			xfer_cnt <= '0;
			issue_cnt <= '0;
			arrive_cnt <= '0;
		end else begin
			case (state)
				IDLE: begin
					// start only counts here
					if (start) begin
						state <= LOAD;
						xfer_cnt <= '0;
						issue_cnt <= '0;
						arrive_cnt <= '0;
					end
				end
				LOAD: begin
					// Counter wraps to 0 for STORE
					if (bus.ack) begin
						xfer_cnt <= xfer_cnt + 6'd1;
						if (xfer_cnt == 6'(2*NUM_LIMBS-1)) begin
							state <= RUN;
						end
					end
				end
				RUN: begin
					if (pass_en) begin
						issue_cnt <= issue_cnt + 6'd1;
					end
					// Leave on the 32nd limb, pipeline is empty by then
					if (limb_valid) begin
						arrive_cnt <= arrive_cnt + 5'd1;
						if (arrive_cnt == pass_idx_t'(NUM_LIMBS-1)) begin
							state <= STORE;
						end
					end
				end
				STORE: begin
					if (bus.ack) begin
						xfer_cnt <= xfer_cnt + 6'd1;
						if (xfer_cnt == 6'(NUM_LIMBS-1)) begin
							state <= DONE;
						end
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	//////////////////////////////////////////////////
	// Operand and result registers

	always_ff @(posedge clk) begin
		// A in natural order, B pre-rotated for pass 0
		if (state == LOAD && bus.ack) begin
			if (xfer_cnt[5]) begin
				opb[load_lane*32 +: 32] <= bus.dat_r;
			end else begin
				opa[xfer_cnt[4:0]*32 +: 32] <= bus.dat_r;
			end
		end
		// Lane j takes lane j-1 per pass, keeps lane j at b[(i-j) mod 32]
		if (pass_en) begin
			opb <= {opb[$bits(bignum_t)-33:0], opb[$bits(bignum_t)-1 -: 32]};
		end
		if (limb_valid) begin
			res[limb_idx*32 +: 32] <= limb;
		end
	end

	//////////////////////////////////////////////////
	// Bus master

	// Held stable until ack, the next word follows at once
	always_comb begin
		bus.cyc = 1'b0;
		bus.stb = 1'b0;
		bus.we = 1'b0;
		bus.adr = OPA_BASE;
		bus.dat_w = res[xfer_cnt[4:0]*32 +: 32];
		case (state)
			LOAD: begin
				bus.cyc = 1'b1;
				bus.stb = 1'b1;
				bus.adr = (xfer_cnt[5] ? OPB_BASE : OPA_BASE) + wb_adr_t'(xfer_cnt[4:0]);
			end
			STORE: begin
				bus.cyc = 1'b1;
				bus.stb = 1'b1;
				bus.we = 1'b1;
				bus.adr = RES_BASE + wb_adr_t'(xfer_cnt[4:0]);
			end
			default: begin
			end
		endcase
	end

	// Pass stream and status
	assign pass_en = state == RUN && !issue_cnt[5];
	assign pass_idx = issue_cnt[4:0];
	assign pass_a = opa;
	assign pass_b = opb;
	assign busy = state != IDLE;
	assign done = state == DONE;

endmodule

// ==== src/wb_arbiter.sv ====
module wb_arbiter (
	input logic clk,
	input logic arst_n,
	wb_if.slave m0,
	wb_if.slave m1,
	wb_if.master s
);

	// Bus owner, 0 is the host and 1 the sequencer
	logic gnt;

	// Request of the owner and of the stalled master
	logic owner_cyc;
	logic other_cyc;

	assign owner_cyc = gnt ? m1.cyc : m0.cyc;
	assign other_cyc = gnt ? m0.cyc : m1.cyc;

	//////////////////////////////////////////////////
	// Grant

	// Owner keeps the bus while its cyc is high
	// Once it lets go, a waiting master takes over
	// So with both waiting, the last owner goes second
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			gnt <= 1'b0;
		end else if (!owner_cyc && other_cyc) begin
			gnt <= ~gnt;
		end
	end

	//////////////////////////////////////////////////
	// Routing

	// Owner request to the memory
	assign s.cyc = owner_cyc;
	assign s.stb = gnt ? m1.stb : m0.stb;
	assign s.we = gnt ? m1.we : m0.we;
	assign s.adr = gnt ? m1.adr : m0.adr;
	assign s.dat_w = gnt ? m1.dat_w : m0.dat_w;

	// Read data fans out, qualified by ack
	assign m0.dat_r = s.dat_r;
	assign m1.dat_r = s.dat_r;

	// Stalled master sees no ack
	assign m0.ack = s.ack && !gnt;
	assign m1.ack = s.ack && gnt;

endmodule

// ==== src/wb_if.sv ====
interface wb_if;
	import x25519_pkg::*;

	// Request side
	logic cyc;
	logic stb;
	logic we;
	wb_adr_t adr;
	limb_t dat_w;

	// Response side
	limb_t dat_r;
	logic ack;

	// Bus owner
	modport master (
		output cyc, stb, we, adr, dat_w,
		input dat_r, ack
	);

	// Target or arbiter input
	modport slave (
		input cyc, stb, we, adr, dat_w,
		output dat_r, ack
	);

endinterface

// ==== src/x25519_mul_top.sv ====
module x25519_mul_top (
	input  logic                clk,
	input  logic                arst_n,
	input  logic                start,
	input  logic                host_cyc,
	input  logic                host_stb,
	input  logic                host_we,
	input  x25519_pkg::wb_adr_t host_adr,
	input  x25519_pkg::limb_t   host_dat_w,
	output x25519_pkg::limb_t   host_dat_r,
	output logic                host_ack,
	output logic                busy,
	output logic                done
);
	import x25519_pkg::*;

	// Host port, sequencer and memory side of the arbiter
	wb_if host_bus ();
	wb_if seq_bus ();
	wb_if mem_bus ();

	// Pass stream
	logic pass_en;
	pass_idx_t pass_idx;
	bignum_t pass_a;
	bignum_t pass_b;
	logic limb_valid;
	pass_idx_t limb_idx;
	limb_t limb;

	//////////////////////////////////////////////////
	// Host port onto its bus

	assign host_bus.cyc = host_cyc;
	assign host_bus.stb = host_stb;
	assign host_bus.we = host_we;
	assign host_bus.adr = host_adr;
	assign host_bus.dat_w = host_dat_w;
	assign host_dat_r = host_bus.dat_r;
	assign host_ack = host_bus.ack;

	//////////////////////////////////////////////////
	// Blocks

	wb_arbiter u_arbiter (
		.clk    (clk),
		.arst_n (arst_n),
		.m0     (host_bus.slave),
		.m1     (seq_bus.slave),
		.s      (mem_bus.master)
	);

	limb_ram u_ram (
		.clk    (clk),
		.arst_n (arst_n),
		.bus    (mem_bus.slave)
	);

	mult_sequencer u_seq (
		.clk        (clk),
		.arst_n     (arst_n),
		.start      (start),
		.limb_valid (limb_valid),
		.limb_idx   (limb_idx),
		.limb       (limb),
		.busy       (busy),
		.done       (done),
		.pass_en    (pass_en),
		.pass_idx   (pass_idx),
		.pass_a     (pass_a),
		.pass_b     (pass_b),
		.bus        (seq_bus.master)
	);

	mult_pass u_pass (
		.clk        (clk),
		.arst_n     (arst_n),
		.pass_en    (pass_en),
		.pass_idx   (pass_idx),
		.pass_a     (pass_a),
		.pass_b     (pass_b),
		.limb_valid (limb_valid),
		.limb_idx   (limb_idx),
		.limb       (limb)
	);

endmodule

// ==== src/x25519_pkg.sv ====
package x25519_pkg;

	//////////////////////////////////////////////////
	// Data types

	// One limb, all arithmetic wraps at 2^32
	typedef logic [31:0] limb_t;

	// Field element, limb j sits at bits 32*j and up
	typedef logic [1023:0] bignum_t;

	// Word address into the limb memory
	typedef logic [6:0] wb_adr_t;

	// Limb index and pass index
	typedef logic [4:0] pass_idx_t;

	// Sequencer FSM
	typedef enum logic [2:0] {
		IDLE,
		LOAD,
		RUN,
		STORE,
		DONE
	} seq_state_t;

	//////////////////////////////////////////////////
	// Sizes and memory map

	localparam int NUM_LIMBS = 32;
	localparam int MEM_WORDS = 128;

	// Operands, then result; words 96 to 127 are host scratch
	localparam wb_adr_t OPA_BASE = 7'd0;
	localparam wb_adr_t OPB_BASE = 7'd32;
	localparam wb_adr_t RES_BASE = 7'd64;

	// Fold factor for terms that wrap past the top limb
	localparam limb_t MUL38 = 32'd38;

	// Pass issue to limb out
	localparam int PASS_LATENCY = 5;

endpackage
